// ==== hdl/ll_auto_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module ll_auto_sync (
  input  logic                             clk_wr,
  input  logic                             rst,
  input  logic                             tx_online,
  input  logic                             rx_online,
  input  logic [lpif_pkg::DELAY_WIDTH-1:0] delay_x_value,
  input  logic [lpif_pkg::DELAY_WIDTH-1:0] delay_y_value,
  input  logic [lpif_pkg::DELAY_WIDTH-1:0] delay_z_value,
  output logic                             tx_online_delay,
  output logic                             rx_online_delay,
  output logic                             tx_stb_userbit,
  output logic                             tx_mrk_userbit
);

  // Channel 0 is transmit and channel 1 is receive
  logic [1:0]                       online_req;
  logic [1:0]                       online_dly;
  logic [lpif_pkg::DELAY_WIDTH-1:0] dly_val [2];
  logic [lpif_pkg::DELAY_WIDTH-1:0] mrk_cnt;

  assign online_req = {rx_online, tx_online};
  assign dly_val[0] = delay_y_value;
  assign dly_val[1] = delay_x_value;

  //////////////////////////////////////////////////////////////////////
  // Online delay counters

  for (genvar ch = 0; ch < 2; ch++) begin : g_dly
    logic [lpif_pkg::DELAY_WIDTH:0] cnt;
    logic [lpif_pkg::DELAY_WIDTH:0] cnt_end;
    logic                           dly_q;

    // One extra bit so that a full-scale delay still terminates
    assign cnt_end = {1'b0, dly_val[ch]} + 1'b1;

    always_ff @(posedge clk_wr) begin
      if (rst || !online_req[ch]) begin
        // Drop at once when the request goes away
        cnt   <= '0;
        dly_q <= 1'b0;
      end else if (cnt == cnt_end) begin
        // Hold once the delay has expired
        dly_q <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end

    assign online_dly[ch] = dly_q;
  end

  assign tx_online_delay = online_dly[0];
  assign rx_online_delay = online_dly[1];

  //////////////////////////////////////////////////////////////////////
  // Marker period and strobe

  // Zero on the first online cycle and then every delay_z_value cycles
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online_delay) begin
      mrk_cnt <= '0;
    end else if (mrk_cnt >= delay_z_value - 1'b1) begin
      mrk_cnt <= '0;
    end else begin
      mrk_cnt <= mrk_cnt + 1'b1;
    end
  end

  // Period of zero disables markers
  assign tx_mrk_userbit = tx_online_delay && (delay_z_value != '0) && (mrk_cnt == '0);
  // Strobe on every online cycle
  assign tx_stb_userbit = tx_online_delay;

  // Neither link comes up without at least two cycles of request
  a_tx_online_min_delay: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(tx_online_delay) |-> $past(tx_online) && $past(tx_online, 2));

  a_rx_online_min_delay: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(rx_online_delay) |-> $past(rx_online) && $past(rx_online, 2));

  // Every online period opens with a marker
  a_mrk_first_online: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(tx_online_delay) && (delay_z_value != '0) |-> tx_mrk_userbit);

endmodule

`default_nettype wire

// ==== hdl/lpif_flit_pack.sv ====
`timescale 1ns/100ps
`default_nettype none

module lpif_flit_pack (
  input  logic                              clk_wr,
  input  logic                              rst,
  input  logic [lpif_pkg::STATE_WIDTH-1:0]  dstrm_state,
  input  logic [lpif_pkg::PROTID_WIDTH-1:0] dstrm_protid,
  input  logic [lpif_pkg::DATA_WIDTH-1:0]   dstrm_data,
  input  logic                              dstrm_dvalid,
  input  logic [lpif_pkg::CRC_WIDTH-1:0]    dstrm_crc,
  input  logic                              dstrm_crc_valid,
  input  logic                              dstrm_valid,
  input  logic [lpif_pkg::FLIT_WIDTH-1:0]   rx_flit,
  input  logic                              rx_online_delay,
  output logic [lpif_pkg::FLIT_WIDTH-1:0]   tx_flit,
  output logic [lpif_pkg::STATE_WIDTH-1:0]  ustrm_state,
  output logic [lpif_pkg::PROTID_WIDTH-1:0] ustrm_protid,
  output logic [lpif_pkg::DATA_WIDTH-1:0]   ustrm_data,
  output logic                              ustrm_dvalid,
  output logic [lpif_pkg::CRC_WIDTH-1:0]    ustrm_crc,
  output logic                              ustrm_crc_valid,
  output logic                              ustrm_valid
);

  logic [lpif_pkg::FLIT_WIDTH-1:0] tx_flit_d;

  //////////////////////////////////////////////////////////////////////
  // Downstream packing

  assign tx_flit_d = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                      dstrm_crc, dstrm_crc_valid, dstrm_valid};

  always_ff @(posedge clk_wr) begin
    tx_flit <= tx_flit_d;
    // Qualifier bits cleared
    if (rst) begin
      tx_flit[lpif_pkg::OFS_VALID]     <= 1'b0;
      tx_flit[lpif_pkg::OFS_CRC_VALID] <= 1'b0;
      tx_flit[lpif_pkg::OFS_DVALID]    <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Upstream unpacking

  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online_delay) begin
      // Outputs held at zero while receive is offline
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_data      <= '0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc       <= '0;
      ustrm_crc_valid <= 1'b0;
      ustrm_valid     <= 1'b0;
    end else begin
      ustrm_state     <= rx_flit[lpif_pkg::OFS_STATE +: lpif_pkg::STATE_WIDTH];
      ustrm_protid    <= rx_flit[lpif_pkg::OFS_PROTID +: lpif_pkg::PROTID_WIDTH];
      ustrm_data      <= rx_flit[lpif_pkg::OFS_DATA +: lpif_pkg::DATA_WIDTH];
      ustrm_dvalid    <= rx_flit[lpif_pkg::OFS_DVALID];
      ustrm_crc       <= rx_flit[lpif_pkg::OFS_CRC +: lpif_pkg::CRC_WIDTH];
      ustrm_crc_valid <= rx_flit[lpif_pkg::OFS_CRC_VALID];
      ustrm_valid     <= rx_flit[lpif_pkg::OFS_VALID];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lpif_lane_stripe.sv ====
`timescale 1ns/100ps
`default_nettype none

module lpif_lane_stripe #(
  parameter int NUM_LANES = 4
) (
  input  logic                                         clk_wr,
  input  logic                                         rst,
  input  logic                                         tx_online,
  input  logic                                         tx_stb_userbit,
  input  logic                                         tx_mrk_userbit,
  input  logic [lpif_pkg::FLIT_WIDTH-1:0]              tx_flit,
  input  logic [NUM_LANES*lpif_pkg::LANE_WIDTH-1:0]    rx_phy,
  output logic [NUM_LANES*lpif_pkg::LANE_WIDTH-1:0]    tx_phy,
  output logic [lpif_pkg::FLIT_WIDTH-1:0]              rx_flit,
  output logic [31:0]                                  tx_downstream_debug_status,
  output logic [31:0]                                  rx_upstream_debug_status
);

  // Payload capacity over all lanes, at least one flit
  localparam int PAY_WIDTH = NUM_LANES * lpif_pkg::LANE_PAYLOAD;

  logic [PAY_WIDTH-1:0]                      tx_payload;
  logic [PAY_WIDTH-1:0]                      rx_payload;
  logic [NUM_LANES*lpif_pkg::LANE_WIDTH-1:0] tx_phy_d;
  logic [NUM_LANES-1:0]                      rx_stb;

  // Spare payload bits on the top lane go out as zero
  assign tx_payload = PAY_WIDTH'(tx_flit);

  //////////////////////////////////////////////////////////////////////
  // Per-lane split and merge, lane 0 lowest

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    localparam int LB = l * lpif_pkg::LANE_WIDTH;
    localparam int PB = l * lpif_pkg::LANE_PAYLOAD;

    assign tx_phy_d[LB +: lpif_pkg::LANE_PAYLOAD] = tx_payload[PB +: lpif_pkg::LANE_PAYLOAD];
    assign tx_phy_d[LB + lpif_pkg::MRK_BIT]       = tx_mrk_userbit;
    assign tx_phy_d[LB + lpif_pkg::STB_BIT]       = tx_stb_userbit;

    // Control bits stripped on receive
    assign rx_payload[PB +: lpif_pkg::LANE_PAYLOAD] = rx_phy[LB +: lpif_pkg::LANE_PAYLOAD];
    assign rx_stb[l] = rx_phy[LB + lpif_pkg::STB_BIT];
  end

  //////////////////////////////////////////////////////////////////////
  // Transmit register

  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online) begin
      // Quiet lanes while offline
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_phy_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive register

  always_ff @(posedge clk_wr) begin
    rx_flit <= rx_payload[lpif_pkg::FLIT_WIDTH-1:0];
    if (rst) begin
      rx_flit[lpif_pkg::OFS_VALID] <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Flit counters, free running and wrapping

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_downstream_debug_status <= '0;
      rx_upstream_debug_status   <= '0;
    end else begin
      // Counted as it enters the lanes
      if (tx_online && tx_flit[lpif_pkg::OFS_VALID]) begin
        tx_downstream_debug_status <= tx_downstream_debug_status + 1'b1;
      end
      // Counted once gathered
      if (rx_flit[lpif_pkg::OFS_VALID]) begin
        rx_upstream_debug_status <= rx_upstream_debug_status + 1'b1;
      end
    end
  end

  // All lanes strobed together by the far side
  a_rx_stb_aligned: assert property (@(posedge clk_wr) disable iff (rst)
    (&rx_stb) || !(|rx_stb));

endmodule

`default_nettype wire

// ==== hdl/lpif_pkg.sv ====
`default_nettype none

package lpif_pkg;

  //////////////////////////////////////////////////////////////////////
  // Flit field widths

  localparam int DATA_WIDTH   = 64;
  localparam int CRC_WIDTH    = 16;
  localparam int STATE_WIDTH  = 4;
  localparam int PROTID_WIDTH = 2;

  //////////////////////////////////////////////////////////////////////
  // Flit field offsets, bit 0 upward

  localparam int OFS_VALID     = 0;
  localparam int OFS_CRC_VALID = OFS_VALID + 1;
  localparam int OFS_CRC       = OFS_CRC_VALID + 1;
  localparam int OFS_DVALID    = OFS_CRC + CRC_WIDTH;
  localparam int OFS_DATA      = OFS_DVALID + 1;
  localparam int OFS_PROTID    = OFS_DATA + DATA_WIDTH;
  localparam int OFS_STATE     = OFS_PROTID + PROTID_WIDTH;

  // Total flit, 89 bits
  localparam int FLIT_WIDTH = OFS_STATE + STATE_WIDTH;

  //////////////////////////////////////////////////////////////////////
  // Lane word layout

  localparam int LANE_WIDTH   = 25;
  // Payload in the low bits
  localparam int LANE_PAYLOAD = 23;
  // Control bits on top
  localparam int STB_BIT      = 24;
  localparam int MRK_BIT      = 23;

  // Online delay configuration values
  localparam int DELAY_WIDTH = 16;

endpackage

`default_nettype wire

// ==== hdl/lpif_txrx_master_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lpif_txrx_master_top #(
  parameter int NUM_LANES = 4
) (
  input  logic                                      clk_wr,
  input  logic                                      rst,
  // Link control
  input  logic                                      tx_online,
  input  logic                                      rx_online,
  // PHY lanes
  output logic [NUM_LANES*lpif_pkg::LANE_WIDTH-1:0] tx_phy,
  input  logic [NUM_LANES*lpif_pkg::LANE_WIDTH-1:0] rx_phy,
  // Downstream channel
  input  logic [lpif_pkg::STATE_WIDTH-1:0]          dstrm_state,
  input  logic [lpif_pkg::PROTID_WIDTH-1:0]         dstrm_protid,
  input  logic [lpif_pkg::DATA_WIDTH-1:0]           dstrm_data,
  input  logic                                      dstrm_dvalid,
  input  logic [lpif_pkg::CRC_WIDTH-1:0]            dstrm_crc,
  input  logic                                      dstrm_crc_valid,
  input  logic                                      dstrm_valid,
  // Upstream channel
  output logic [lpif_pkg::STATE_WIDTH-1:0]          ustrm_state,
  output logic [lpif_pkg::PROTID_WIDTH-1:0]         ustrm_protid,
  output logic [lpif_pkg::DATA_WIDTH-1:0]           ustrm_data,
  output logic                                      ustrm_dvalid,
  output logic [lpif_pkg::CRC_WIDTH-1:0]            ustrm_crc,
  output logic                                      ustrm_crc_valid,
  output logic                                      ustrm_valid,
  // Flit counts
  output logic [31:0]                               tx_downstream_debug_status,
  output logic [31:0]                               rx_upstream_debug_status,
  // Static configuration
  input  logic [lpif_pkg::DELAY_WIDTH-1:0]          delay_x_value,
  input  logic [lpif_pkg::DELAY_WIDTH-1:0]          delay_y_value,
  input  logic [lpif_pkg::DELAY_WIDTH-1:0]          delay_z_value
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect

  logic [lpif_pkg::FLIT_WIDTH-1:0] tx_flit;
  logic [lpif_pkg::FLIT_WIDTH-1:0] rx_flit;
  logic                            tx_online_delay;
  logic                            rx_online_delay;
  logic                            tx_stb_userbit;
  logic                            tx_mrk_userbit;

  // Online delays and marker/strobe generation
  ll_auto_sync ll_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_mrk_userbit  (tx_mrk_userbit)
  );

  // Field packing, user side
  lpif_flit_pack lpif_flit_pack_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .rx_flit         (rx_flit),
    .rx_online_delay (rx_online_delay),
    .tx_flit         (tx_flit),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  // Lane striping, PHY side
  lpif_lane_stripe #(
    .NUM_LANES (NUM_LANES)
  ) lpif_lane_stripe_i (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_online                  (tx_online_delay),
    .tx_stb_userbit             (tx_stb_userbit),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_flit                    (tx_flit),
    .rx_phy                     (rx_phy),
    .tx_phy                     (tx_phy),
    .rx_flit                    (rx_flit),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

endmodule

`default_nettype wire

// ==== lpif_txrx_master_top.f ====
hdl/lpif_pkg.sv
hdl/ll_auto_sync.sv
hdl/lpif_flit_pack.sv
hdl/lpif_lane_stripe.sv
hdl/lpif_txrx_master_top.sv
tb/lpif_txrx_master_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the loopback testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module lpif_txrx_master_tb -f lpif_txrx_master_top.f \
  -o lpif_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/lpif_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation ended abnormally"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0

// ==== tb/lpif_txrx_master_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lpif_txrx_master_tb;

  localparam int NUM_LANES    = 4;
  localparam int PHY_WIDTH    = NUM_LANES * lpif_pkg::LANE_WIDTH;
  localparam int FW           = lpif_pkg::FLIT_WIDTH;
  localparam int CTRL_W       = lpif_pkg::STATE_WIDTH + lpif_pkg::PROTID_WIDTH + 3;
  localparam int DLY_X        = 3;
  localparam int DLY_Y        = 5;
  localparam int DLY_Z        = 7;
  localparam int RST_CYCLES   = 8;
  localparam int PRE_CYCLES   = 40;
  localparam int NUM_FLITS    = 200;
  localparam int TAIL_CYCLES  = 16;
  localparam int DRAIN_CYCLES = 20;
  // Watchdog limit is twice the whole run
  localparam int TEST_CYCLES  = RST_CYCLES + PRE_CYCLES + NUM_FLITS
                                + 2 * TAIL_CYCLES + DRAIN_CYCLES;
  localparam int MAX_CYCLES   = 2 * TEST_CYCLES;

  logic                              clk_wr;
  logic                              rst;
  logic                              tx_online;
  logic                              rx_online;
  logic [PHY_WIDTH-1:0]              phy;
  logic [lpif_pkg::STATE_WIDTH-1:0]  dstrm_state;
  logic [lpif_pkg::PROTID_WIDTH-1:0] dstrm_protid;
  logic [lpif_pkg::DATA_WIDTH-1:0]   dstrm_data;
  logic                              dstrm_dvalid;
  logic [lpif_pkg::CRC_WIDTH-1:0]    dstrm_crc;
  logic                              dstrm_crc_valid;
  logic                              dstrm_valid;
  logic [lpif_pkg::STATE_WIDTH-1:0]  ustrm_state;
  logic [lpif_pkg::PROTID_WIDTH-1:0] ustrm_protid;
  logic [lpif_pkg::DATA_WIDTH-1:0]   ustrm_data;
  logic                              ustrm_dvalid;
  logic [lpif_pkg::CRC_WIDTH-1:0]    ustrm_crc;
  logic                              ustrm_crc_valid;
  logic                              ustrm_valid;
  logic [31:0]                       tx_cnt;
  logic [31:0]                       rx_cnt;
  logic [lpif_pkg::DELAY_WIDTH-1:0]  delay_x_value;
  logic [lpif_pkg::DELAY_WIDTH-1:0]  delay_y_value;
  logic [lpif_pkg::DELAY_WIDTH-1:0]  delay_z_value;

  // Model state as of the latest rising edge
  int                   tx_run;
  int                   rx_run;
  logic                 tx_on_m;
  logic                 rx_on_m;
  logic                 mrk_m;
  logic [FW-1:0]        tx_flit_m;
  logic [FW-1:0]        exp_up;
  logic [PHY_WIDTH-1:0] exp_tx_phy;
  logic [31:0]          exp_tx_cnt;
  logic [31:0]          exp_rx_cnt;
  logic [FW-1:0]        lane_q[$];

  logic [31:0] rnd;
  int          cycle_cnt;
  int          check_cnt;
  int          err_cnt;

  // PHY lanes looped straight back
  lpif_txrx_master_top #(
    .NUM_LANES (NUM_LANES)
  ) dut_i (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .tx_phy                     (phy),
    .rx_phy                     (phy),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_cnt),
    .rx_upstream_debug_status   (rx_cnt),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value)
  );

  initial begin
    clk_wr = 1'b0;
    forever #2 clk_wr = ~clk_wr;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference functions

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Fields placed at their flit offsets
  function automatic logic [FW-1:0] pack_flit(
    input logic [lpif_pkg::STATE_WIDTH-1:0]  state,
    input logic [lpif_pkg::PROTID_WIDTH-1:0] protid,
    input logic [lpif_pkg::DATA_WIDTH-1:0]   data,
    input logic                              dvalid,
    input logic [lpif_pkg::CRC_WIDTH-1:0]    crc,
    input logic                              crc_valid,
    input logic                              valid
  );
    logic [FW-1:0] f;
    f = '0;
    f[lpif_pkg::OFS_STATE +: lpif_pkg::STATE_WIDTH]   = state;
    f[lpif_pkg::OFS_PROTID +: lpif_pkg::PROTID_WIDTH] = protid;
    f[lpif_pkg::OFS_DATA +: lpif_pkg::DATA_WIDTH]     = data;
    f[lpif_pkg::OFS_DVALID]                           = dvalid;
    f[lpif_pkg::OFS_CRC +: lpif_pkg::CRC_WIDTH]       = crc;
    f[lpif_pkg::OFS_CRC_VALID]                        = crc_valid;
    f[lpif_pkg::OFS_VALID]                            = valid;
    return f;
  endfunction

  // Expected lane words as 23-bit slices with strobe and marker on top
  function automatic logic [PHY_WIDTH-1:0] lane_words(
    input logic [FW-1:0] flit,
    input logic          stb,
    input logic          mrk
  );
    logic [NUM_LANES*lpif_pkg::LANE_PAYLOAD-1:0] pay;
    logic [PHY_WIDTH-1:0]                        w;
    pay         = '0;
    pay[FW-1:0] = flit;
    w           = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      w[l*lpif_pkg::LANE_WIDTH +: lpif_pkg::LANE_PAYLOAD] =
        pay[l*lpif_pkg::LANE_PAYLOAD +: lpif_pkg::LANE_PAYLOAD];
      w[l*lpif_pkg::LANE_WIDTH + lpif_pkg::MRK_BIT] = mrk;
      w[l*lpif_pkg::LANE_WIDTH + lpif_pkg::STB_BIT] = stb;
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_lanes(input logic [PHY_WIDTH-1:0] got, input logic [PHY_WIDTH-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: tx_phy is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_data(input logic [lpif_pkg::DATA_WIDTH-1:0] got,
                            input logic [lpif_pkg::DATA_WIDTH-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: ustrm_data is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_crc(input logic [lpif_pkg::CRC_WIDTH-1:0] got,
                           input logic [lpif_pkg::CRC_WIDTH-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: ustrm_crc is %h, expected %h", $time, got, exp);
    end
  endtask

  // state, protid, dvalid, crc_valid, valid in one word
  task automatic check_ctrl(input logic [CTRL_W-1:0] got, input logic [CTRL_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: upstream control is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_count(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Cycle model of the inputs sampled at the rising edge

  always @(posedge clk_wr) begin : ref_model
    logic [FW-1:0] aged;
    // Upstream lags the lanes by two edges
    aged   = lane_q.pop_front();
    exp_up = (rx_on_m && !rst) ? aged : '0;
    if (rst) begin
      exp_rx_cnt = '0;
    end else if (aged[lpif_pkg::OFS_VALID]) begin
      exp_rx_cnt = exp_rx_cnt + 1;
    end
    // Lanes lag the packer by one edge
    lane_q.push_back(tx_on_m ? tx_flit_m : '0);
    exp_tx_phy = tx_on_m ? lane_words(tx_flit_m, 1'b1, mrk_m) : '0;
    if (rst) begin
      exp_tx_cnt = '0;
    end else if (tx_on_m && tx_flit_m[lpif_pkg::OFS_VALID]) begin
      exp_tx_cnt = exp_tx_cnt + 1;
    end
    tx_flit_m = pack_flit(dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                          dstrm_crc, dstrm_crc_valid, dstrm_valid);
    // Online after delay+1 cycles of request and marker phase from the first online cycle
    tx_run  = (rst || !tx_online) ? 0 : tx_run + 1;
    rx_run  = (rst || !rx_online) ? 0 : rx_run + 1;
    tx_on_m = (tx_run >= DLY_Y + 2);
    rx_on_m = (rx_run >= DLY_X + 2);
    mrk_m   = tx_on_m && (DLY_Z != 0) && ((tx_run - DLY_Y - 2) % DLY_Z == 0);
  end

  // Outputs settled by the falling edge
  always @(negedge clk_wr) begin : compare
    if (!rst) begin
      check_lanes(phy, exp_tx_phy);
      check_data(ustrm_data, exp_up[lpif_pkg::OFS_DATA +: lpif_pkg::DATA_WIDTH]);
      check_crc(ustrm_crc, exp_up[lpif_pkg::OFS_CRC +: lpif_pkg::CRC_WIDTH]);
      check_ctrl({ustrm_state, ustrm_protid, ustrm_dvalid, ustrm_crc_valid, ustrm_valid},
                 {exp_up[lpif_pkg::OFS_STATE +: lpif_pkg::STATE_WIDTH],
                  exp_up[lpif_pkg::OFS_PROTID +: lpif_pkg::PROTID_WIDTH],
                  exp_up[lpif_pkg::OFS_DVALID], exp_up[lpif_pkg::OFS_CRC_VALID],
                  exp_up[lpif_pkg::OFS_VALID]});
      check_count(tx_cnt, exp_tx_cnt, "tx flit count");
      check_count(rx_cnt, exp_rx_cnt, "rx flit count");
    end
  end

  always @(posedge clk_wr) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("Run stopped, no end after %0d cycles", MAX_CYCLES);
      $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  // New random flit driven just after the edge
  task automatic drive_flit();
    @(posedge clk_wr);
    #0.5;
    rnd = lcg_next(rnd);
    dstrm_data[63:32] = rnd;
    rnd = lcg_next(rnd);
    dstrm_data[31:0] = rnd;
    rnd = lcg_next(rnd);
    dstrm_crc = rnd[31:16];
    rnd = lcg_next(rnd);
    // Upper LCG bits since the low ones repeat quickly
    dstrm_state     = rnd[31:28];
    dstrm_protid    = rnd[27:26];
    dstrm_dvalid    = rnd[25];
    dstrm_crc_valid = rnd[24];
    dstrm_valid     = rnd[23] | rnd[22];
  endtask

  task automatic drive_idle();
    @(posedge clk_wr);
    #0.5;
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = 1'b0;
    dstrm_crc       = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid     = 1'b0;
  endtask

  initial begin : stimulus
    rst             = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = 1'b0;
    dstrm_crc       = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid     = 1'b0;
    delay_x_value   = DLY_X;
    delay_y_value   = DLY_Y;
    delay_z_value   = DLY_Z;
    rnd             = 32'h8bfac822;
    tx_run          = 0;
    rx_run          = 0;
    tx_on_m         = 1'b0;
    rx_on_m         = 1'b0;
    mrk_m           = 1'b0;
    tx_flit_m       = '0;
    exp_up          = '0;
    exp_tx_phy      = '0;
    exp_tx_cnt      = '0;
    exp_rx_cnt      = '0;
    cycle_cnt       = 0;
    check_cnt       = 0;
    err_cnt         = 0;
    // Two flits in flight between lanes and upstream
    lane_q.push_back('0);
    lane_q.push_back('0);

    repeat (RST_CYCLES) @(posedge clk_wr);
    #0.5;
    rst       = 1'b0;
    tx_online = 1'b1;
    // Transmit comes up while receive is still down
    repeat (PRE_CYCLES) drive_flit();
    rx_online = 1'b1;
    repeat (NUM_FLITS) drive_flit();
    // Receive drops first and transmit after it
    rx_online = 1'b0;
    repeat (TAIL_CYCLES) drive_flit();
    tx_online = 1'b0;
    repeat (TAIL_CYCLES) drive_flit();
    drive_idle();
    repeat (DRAIN_CYCLES) @(posedge clk_wr);
    #0.5;

    check_count(rx_cnt, exp_tx_cnt, "final rx count against flits sent");
    if (rx_cnt < NUM_FLITS / 2) begin
      err_cnt++;
      $display("Too few flits made it around the loop: %0d", rx_cnt);
    end
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
